// ==== verilog/fano_pkg.sv ====
package fano_pkg;

    ////////////////////////////////////////////////////////////
    // Code and window sizes
    ////////////////////////////////////////////////////////////
    localparam int WIN_LEN  = 64;  // Path window depth in branches
    localparam int CODE_MEM = 24;  // Decoded bits feeding the parity

    // Branch is {info, parity}
    typedef logic [1:0] branch_t;

    // Decoded history, index 0 holds the newest past bit
    typedef logic [CODE_MEM-1:0] history_t;

    typedef logic signed [5:0]  bm_t;           // Branch metric
    typedef logic signed [15:0] path_metric_t;  // Path metrics and threshold
    typedef logic [6:0]         ptr_t;          // Window index

    // Parity = info ^ (^(history & PARITY_TAPS))
    // Low taps set so a wrong bit shows up in the next few branches
    localparam history_t PARITY_TAPS = 24'h9A5C37;

    ////////////////////////////////////////////////////////////
    // Fano metric and threshold control
    ////////////////////////////////////////////////////////////
    localparam bm_t          MATCH_GAIN    = 6'sd1;
    localparam bm_t          MISMATCH_COST = 6'sd9;
    localparam path_metric_t DELTA_T       = 16'sd4;
    localparam path_metric_t NORM_LEVEL    = 16'sd256;  // T halved here
    localparam ptr_t         PTR_MAX       = ptr_t'(WIN_LEN - CODE_MEM);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_METRIC,
        ST_FORWARD,
        ST_BACKWARD
    } fano_state_t;

    // What one tree node shows to an encoder/metric pair
    typedef struct packed {
        branch_t  rx;
        history_t history;
        logic     worse;
    } node_view_t;

    // Expected branches for decoded bit 0 and 1
    typedef struct packed {
        branch_t exp0;
        branch_t exp1;
    } branch_pair_t;

    // One pulse per field
    typedef struct packed {
        logic fwd;
        logic back;
        logic invert_flag;
        logic clear_flag;
    } move_cmd_t;

endpackage

// ==== verilog/branch_encoder.sv ====
`timescale 1ns/1ps

module branch_encoder import fano_pkg::*; (
    input  logic         clk,
    input  logic         nlocal_rst,
    input  logic         i_start,
    input  history_t     i_history,
    output logic         o_vld,
    output branch_pair_t o_pair
);

    logic tap_parity;

    // History part of the parity, shared by both hypotheses
    assign tap_parity = ^(i_history & PARITY_TAPS);

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            o_vld <= 1'b0;
        end else begin
            o_vld <= i_start;
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_pair.exp0 <= {1'b0, tap_parity};
            o_pair.exp1 <= {1'b1, ~tap_parity};  // Info bit flips the parity
        end
    end

endmodule

// ==== verilog/branch_metric.sv ====
`timescale 1ns/1ps

module branch_metric import fano_pkg::*; (
    input  logic         clk,
    input  logic         nlocal_rst,
    input  logic         i_vld,
    input  branch_pair_t i_pair,
    input  branch_t      i_rx,
    input  logic         i_worse,
    output logic         o_vld,
    output bm_t          o_metric,
    output logic         o_sym
);

    bm_t  score0;
    bm_t  score1;
    logic pick1;

    function automatic bm_t bit_score(logic expected, logic received);
        return (expected == received) ? MATCH_GAIN : -MISMATCH_COST;
    endfunction

    // +2, -8 or -18 per branch
    assign score0 = bit_score(i_pair.exp0[1], i_rx[1]) + bit_score(i_pair.exp0[0], i_rx[0]);
    assign score1 = bit_score(i_pair.exp1[1], i_rx[1]) + bit_score(i_pair.exp1[0], i_rx[0]);

    // Tie goes to 0, worse flag takes the other one
    assign pick1 = (score1 > score0) ^ i_worse;

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            o_vld <= 1'b0;
        end else begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            o_metric <= pick1 ? score1 : score0;
            o_sym    <= pick1;
        end
    end

endmodule

// ==== verilog/path_memory.sv ====
`timescale 1ns/1ps

module path_memory import fano_pkg::*; (
    input  logic       clk,
    input  logic       nlocal_rst,
    input  logic       i_vld,
    input  branch_t    i_branch,
    input  move_cmd_t  i_move,
    input  logic       i_dec_sym,
    output node_view_t o_fwd_view,
    output node_view_t o_back_view,
    output logic       o_pointer_nonzero,
    output logic       o_worse_here,
    output logic       o_vld,
    output logic       o_dec_sym
);

    logic [WIN_LEN-1:0] rx_d_q;     // Received info bits
    logic [WIN_LEN-1:0] rx_p_q;     // Received parity bits
    logic [WIN_LEN-1:0] dec_q;
    logic [WIN_LEN-1:0] worse_q;
    logic [WIN_LEN-1:0] dec_n;
    logic [WIN_LEN-1:0] worse_n;
    logic [WIN_LEN-1:0] node_mask;
    logic [WIN_LEN-1:0] fwd_hist;
    logic [WIN_LEN-1:0] back_hist;
    ptr_t               pointer_q;  // Undecoded branches in the window
    ptr_t               pointer_n;
    ptr_t               fwd_idx;
    ptr_t               node;

    // Out of range index reads as 0
    function automatic logic bit_at(logic [WIN_LEN-1:0] vec, ptr_t idx);
        logic [WIN_LEN-1:0] shifted;
        shifted = vec >> idx;
        return shifted[0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Node views
    ////////////////////////////////////////////////////////////
    assign fwd_idx   = pointer_q - 1'b1;
    assign fwd_hist  = dec_q >> pointer_q;
    assign back_hist = dec_q >> (pointer_q + 1'b1);

    assign o_fwd_view.rx       = {bit_at(rx_d_q, fwd_idx), bit_at(rx_p_q, fwd_idx)};
    assign o_fwd_view.history  = fwd_hist[CODE_MEM-1:0];
    assign o_fwd_view.worse    = bit_at(worse_q, fwd_idx);
    assign o_back_view.rx      = {bit_at(rx_d_q, pointer_q), bit_at(rx_p_q, pointer_q)};
    assign o_back_view.history = back_hist[CODE_MEM-1:0];
    assign o_back_view.worse   = bit_at(worse_q, pointer_q);

    assign o_pointer_nonzero = (pointer_q != '0);
    assign o_worse_here      = o_fwd_view.worse;

    always_comb begin
        pointer_n = pointer_q;
        if (i_vld && (pointer_n < PTR_MAX)) pointer_n = pointer_n + 1'b1;
        if (i_move.back && (pointer_n < PTR_MAX)) pointer_n = pointer_n + 1'b1;
        if (i_move.fwd && (pointer_n != '0)) pointer_n = pointer_n - 1'b1;
    end

    // Decisions and flags, with the shift applied first
    always_comb begin
        dec_n   = dec_q;
        worse_n = worse_q;
        node    = fwd_idx;
        if (i_vld) begin
            dec_n   = {dec_q[WIN_LEN-2:0], 1'b0};
            worse_n = {worse_q[WIN_LEN-2:0], 1'b0};
            node    = pointer_q;  // Same node, one place up
        end
        node_mask = {{(WIN_LEN-1){1'b0}}, 1'b1} << node;
        if (i_move.fwd) begin
            dec_n   = i_dec_sym ? (dec_n | node_mask) : (dec_n & ~node_mask);
            worse_n = worse_n & ~(node_mask >> 1);  // Child starts on its best branch
        end
        if (i_move.invert_flag) worse_n = worse_n | node_mask;
        if (i_move.clear_flag) worse_n = worse_n & ~node_mask;
    end

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            pointer_q <= '0;
            dec_q     <= '0;
            worse_q   <= '0;
            o_vld     <= 1'b0;
        end else begin
            pointer_q <= pointer_n;
            dec_q     <= dec_n;
            worse_q   <= worse_n;
            o_vld     <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            rx_d_q    <= {rx_d_q[WIN_LEN-2:0], i_branch[1]};
            rx_p_q    <= {rx_p_q[WIN_LEN-2:0], i_branch[0]};
            o_dec_sym <= dec_q[WIN_LEN-1];  // Oldest decision leaves
        end
    end

endmodule

// ==== verilog/fano_ctrl.sv ====
`timescale 1ns/1ps

module fano_ctrl import fano_pkg::*; (
    input  logic      clk,
    input  logic      nlocal_rst,
    input  logic      i_shift,
    input  logic      i_pointer_nonzero,
    input  logic      i_worse_here,
    input  logic      i_fwd_metric_vld,
    input  bm_t       i_fwd_metric,
    input  logic      i_back_metric_vld,
    input  bm_t       i_back_metric,
    output logic      o_calc_fwd,
    output logic      o_calc_back,
    output move_cmd_t o_move
);

    fano_state_t  state_q;
    fano_state_t  state_n;
    path_metric_t t_q;      // Running threshold
    path_metric_t mc_q;     // Current node
    path_metric_t mp_q;     // Predecessor node
    path_metric_t ms_q;     // Successor under test
    path_metric_t t_plus;
    logic         ms_vld_q;
    logic         mp_vld_q;
    logic         calc_back_q;
    logic         norm_en_q;
    logic [7:0]   fwd_cnt_q;  // Tree depth, saturating
    logic         t_up;
    logic         t_down;
    logic         metric_norm;
    logic         ms_ge_t;
    logic         mp_ge_t;

    assign t_plus      = t_q + DELTA_T;
    assign ms_ge_t     = (ms_q >= t_q);
    assign mp_ge_t     = (mp_q >= t_q);
    assign o_calc_back = calc_back_q;  // One cycle after the pointer moved back

    ////////////////////////////////////////////////////////////
    // Tree search FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_n     = state_q;
        o_calc_fwd  = 1'b0;
        o_move      = '0;
        t_up        = 1'b0;
        t_down      = 1'b0;
        metric_norm = 1'b0;
        case (state_q)
            ST_INIT: begin
                if (i_shift) state_n = ST_IDLE;  // Armed by the first branch
            end
            ST_IDLE: begin
                if (norm_en_q && (t_q == NORM_LEVEL)) metric_norm = 1'b1;
                if (i_pointer_nonzero) begin
                    o_calc_fwd        = 1'b1;
                    o_move.clear_flag = 1'b1;  // Start on the best branch
                    state_n           = ST_METRIC;
                end
            end
            ST_METRIC: begin
                if (ms_vld_q) begin
                    if (ms_ge_t) begin
                        o_move.fwd = 1'b1;
                        state_n    = ST_FORWARD;
                    end else if (mp_ge_t) begin
                        o_move.back = 1'b1;
                        state_n     = ST_BACKWARD;
                    end else begin
                        t_down  = 1'b1;
                        state_n = ST_IDLE;
                    end
                end
            end
            ST_FORWARD: begin
                // First visit of this node, tighten
                if (mp_q < t_plus) t_up = 1'b1;
                state_n = ST_IDLE;
            end
            ST_BACKWARD: begin
                if (mp_vld_q) begin
                    if (i_worse_here) begin
                        // Both branches tried here already
                        if (mp_ge_t) begin
                            o_move.back = 1'b1;
                        end else begin
                            t_down  = 1'b1;
                            state_n = ST_IDLE;
                        end
                    end else begin
                        o_move.invert_flag = 1'b1;
                        o_calc_fwd         = 1'b1;
                        state_n            = ST_METRIC;
                    end
                end
            end
            default: state_n = ST_INIT;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Threshold, metrics and depth
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            state_q     <= ST_INIT;
            t_q         <= '0;
            mc_q        <= '0;
            mp_q        <= 16'sh8000;  // Root has no predecessor
            ms_vld_q    <= 1'b0;
            mp_vld_q    <= 1'b0;
            calc_back_q <= 1'b0;
            norm_en_q   <= 1'b0;
            fwd_cnt_q   <= '0;
        end else begin
            state_q     <= state_n;
            ms_vld_q    <= i_fwd_metric_vld;
            mp_vld_q    <= i_back_metric_vld;
            calc_back_q <= o_move.back;

            if (t_down) t_q <= t_q - DELTA_T;
            else if (t_up) t_q <= t_plus;
            else if (metric_norm) t_q <= t_q >>> 1;

            if (o_move.fwd) begin
                mp_q <= mc_q;
                mc_q <= ms_q;
            end else if (o_move.back) begin
                mc_q <= mp_q;
            end else if (metric_norm) begin
                mc_q <= mc_q >>> 1;
                mp_q <= mp_q >>> 1;
            end else if (i_back_metric_vld) begin
                if (fwd_cnt_q == 8'd0) mp_q <= 16'sh8000;
                else if (fwd_cnt_q == 8'd1) mp_q <= '0;  // Parent is the root
                else mp_q <= mp_q - path_metric_t'(i_back_metric);
            end

            if (o_move.fwd && (fwd_cnt_q != 8'hFF)) fwd_cnt_q <= fwd_cnt_q + 1'b1;
            else if (o_move.back && (fwd_cnt_q != 8'h00)) fwd_cnt_q <= fwd_cnt_q - 1'b1;

            if (metric_norm) norm_en_q <= 1'b0;
            else if (state_q == ST_METRIC) norm_en_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fwd_metric_vld) ms_q <= mc_q + path_metric_t'(i_fwd_metric);
    end

endmodule

// ==== verilog/fano_decoder.sv ====
`timescale 1ns/1ps

module fano_decoder import fano_pkg::*; (
    input  logic    clk,
    input  logic    nlocal_rst,
    input  logic    i_vld,
    input  branch_t i_branch,
    output logic    o_vld,
    output logic    o_dec_sym
);

    node_view_t   fwd_view;
    node_view_t   back_view;
    move_cmd_t    move;
    logic         calc_fwd;
    logic         calc_back;
    logic         pointer_nonzero;
    logic         worse_here;

    // Forward pair
    logic         fwd_enc_vld;
    branch_pair_t fwd_pair;
    logic         fwd_bm_vld;
    bm_t          fwd_bm;
    logic         fwd_sym;

    // Recalculation pair for Mp on the way back
    logic         back_enc_vld;
    branch_pair_t back_pair;
    logic         back_bm_vld;
    bm_t          back_bm;

    fano_ctrl u_ctrl (
        .clk               (clk),
        .nlocal_rst        (nlocal_rst),
        .i_shift           (i_vld),
        .i_pointer_nonzero (pointer_nonzero),
        .i_worse_here      (worse_here),
        .i_fwd_metric_vld  (fwd_bm_vld),
        .i_fwd_metric      (fwd_bm),
        .i_back_metric_vld (back_bm_vld),
        .i_back_metric     (back_bm),
        .o_calc_fwd        (calc_fwd),
        .o_calc_back       (calc_back),
        .o_move            (move)
    );

    path_memory u_path_memory (
        .clk               (clk),
        .nlocal_rst        (nlocal_rst),
        .i_vld             (i_vld),
        .i_branch          (i_branch),
        .i_move            (move),
        .i_dec_sym         (fwd_sym),
        .o_fwd_view        (fwd_view),
        .o_back_view       (back_view),
        .o_pointer_nonzero (pointer_nonzero),
        .o_worse_here      (worse_here),
        .o_vld             (o_vld),
        .o_dec_sym         (o_dec_sym)
    );

    branch_encoder u_fwd_enc (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_start    (calc_fwd),
        .i_history  (fwd_view.history),
        .o_vld      (fwd_enc_vld),
        .o_pair     (fwd_pair)
    );

    branch_metric u_fwd_metric (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_vld      (fwd_enc_vld),
        .i_pair     (fwd_pair),
        .i_rx       (fwd_view.rx),
        .i_worse    (fwd_view.worse),
        .o_vld      (fwd_bm_vld),
        .o_metric   (fwd_bm),
        .o_sym      (fwd_sym)
    );

    branch_encoder u_back_enc (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_start    (calc_back),
        .i_history  (back_view.history),
        .o_vld      (back_enc_vld),
        .o_pair     (back_pair)
    );

    // Symbol not needed, the bit is already in the window
    branch_metric u_back_metric (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_vld      (back_enc_vld),
        .i_pair     (back_pair),
        .i_rx       (back_view.rx),
        .i_worse    (back_view.worse),
        .o_vld      (back_bm_vld),
        .o_metric   (back_bm),
        .o_sym      ()
    );

endmodule

// ==== verif/tb_code_model.svh ====
`ifndef TB_CODE_MODEL_SVH
`define TB_CODE_MODEL_SVH

// Encoder history, newest past bit at index 0
logic [CODE_MEM-1:0] model_hist;
logic                exp_queue[$];  // Info bits waiting to leave the window

// Empty history and WIN_LEN zeros ahead of the first real bit
task automatic model_reset();
    int k;
    model_hist = '0;
    exp_queue.delete();
    for (k = 0; k < WIN_LEN; k++) exp_queue.push_back(1'b0);
endtask

// Systematic branch for one info bit, and the bit due at the output now
task automatic model_step(input logic info, output branch_t br, output logic exp_sym);
    br         = {info, info ^ (^(model_hist & PARITY_TAPS))};
    model_hist = {model_hist[CODE_MEM-2:0], info};
    exp_queue.push_back(info);
    exp_sym = exp_queue.pop_front();
endtask

`endif

// ==== verif/tb_fano_decoder.sv ====
`timescale 1ns/1ps

module tb_fano_decoder import fano_pkg::*; ();

    localparam int STROBE_GAP    = 48;
    localparam int TOTAL_STROBES = 50 + 200 + 300 + 600;
    localparam int CYCLE_LIMIT   = TOTAL_STROBES * STROBE_GAP + 2000;

    logic    clk;
    logic    nlocal_rst;
    logic    i_vld;
    branch_t i_branch;
    logic    o_vld;
    logic    o_dec_sym;

    integer  seed;
    int      cycle_cnt = 0;
    int      error_cnt;
    int      tests_run;
    int      tests_failed;

    `include "tb_code_model.svh"

    fano_decoder DUT (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_vld      (i_vld),
        .i_branch   (i_branch),
        .o_vld      (o_vld),
        .o_dec_sym  (o_dec_sym)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
            error_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_cnt == errs_before) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, error_cnt - errs_before);
        end
    endtask

    // One strobe and the quiet gap up to the next one
    task automatic send_branch(input branch_t br, input logic exp_sym);
        @(posedge clk);
        #2;
        i_vld    = 1'b1;
        i_branch = br;
        @(negedge clk);
        check_bit("o_vld", 1'b0, o_vld);  // Strobe not sampled yet
        @(posedge clk);
        #2;
        i_vld = 1'b0;
        @(negedge clk);
        check_bit("o_vld", 1'b1, o_vld);  // Exactly one cycle later
        check_bit("o_dec_sym", exp_sym, o_dec_sym);
        repeat (STROBE_GAP - 2) begin
            @(negedge clk);
            check_bit("o_vld", 1'b0, o_vld);
        end
    endtask

    // Random info bit through the model and flip_mask on the channel
    task automatic send_random_bit(input branch_t flip_mask);
        logic [31:0] rnd;
        branch_t     br;
        logic        exp_sym;
        rnd = $random(seed);
        model_step(rnd[0], br, exp_sym);
        send_branch(br ^ flip_mask, exp_sym);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic idle_after_reset();
        int errs_before;
        errs_before = error_cnt;
        repeat (20) begin
            @(negedge clk);
            check_bit("o_vld", 1'b0, o_vld);
        end
        finish_test("Test 1 reset state", errs_before);
    endtask

    task automatic strobe_pairing();
        int errs_before;
        errs_before = error_cnt;
        repeat (50) send_random_bit(2'b00);
        finish_test("Test 2 strobe pairing", errs_before);
    endtask

    task automatic clean_channel();
        int errs_before;
        errs_before = error_cnt;
        repeat (200) send_random_bit(2'b00);
        finish_test("Test 3 clean channel", errs_before);
    endtask

    // Info and parity bits hit in turn
    task automatic sparse_errors();
        int      errs_before;
        int      i;
        branch_t flip_mask;
        errs_before = error_cnt;
        for (i = 0; i < 300; i++) begin
            flip_mask = 2'b00;
            if ((i % 40) == 39) flip_mask = ((i / 40) % 2 == 1) ? 2'b10 : 2'b01;
            send_random_bit(flip_mask);
        end
        finish_test("Test 4 sparse errors", errs_before);
    endtask

    task automatic long_clean_run();
        int errs_before;
        errs_before = error_cnt;
        repeat (600) send_random_bit(2'b00);  // Enough to normalize T several times
        finish_test("Test 5 long clean run", errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        nlocal_rst   = 1'b0;
        i_vld        = 1'b0;
        i_branch     = '0;
        seed         = 32'h0e4f616d;
        error_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_reset();

        repeat (16) @(posedge clk);
        #2;
        nlocal_rst = 1'b1;

        idle_after_reset();
        strobe_pairing();
        clean_channel();
        sparse_errors();
        long_clean_run();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_cnt);
        if (error_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verif
verilog/fano_pkg.sv
verilog/branch_encoder.sv
verilog/branch_metric.sv
verilog/path_memory.sv
verilog/fano_ctrl.sv
verilog/fano_decoder.sv
verif/tb_fano_decoder.sv

// ==== Makefile ====
TOP = tb_fano_decoder

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir
